/* tb/dm_patterns.txt */
// columns: op (1 read, 2 write), dmi address, write data, expected response data,
// hart_halted, hart_resumeack; all values hex
1 11 00000000 000c0c82 0 0
1 12 00000000 00211380 0 0
2 10 80000001 00000000 0 0
1 11 00000000 000c0382 1 0
1 10 00000000 80000001 1 0
1 40 00000000 00000001 1 0
2 10 00010001 00000000 1 0
1 11 00000000 000cc082 1 0
2 10 40000001 00000000 1 0
1 10 00000000 40000001 1 0
1 11 00000000 000f0c82 0 1
1 10 00000000 00000001 0 1
2 10 10000001 00000000 0 0
1 11 00000000 00000c82 0 0
2 10 00000003 00000000 0 0
1 11 00000000 000c0c82 0 0
2 10 00000001 00000000 0 0
2 38 00100000 00000000 0 0
2 39 00000010 00000000 0 0
2 3c cafe1234 00000000 0 0
2 39 00000010 00000000 0 0
1 3c 00000000 cafe1234 0 0
2 38 00110000 00000000 0 0
2 3c 0badf00d 00000000 0 0
1 39 00000000 00000014 0 0
2 39 00000010 00000000 0 0
1 3c 00000000 0badf00d 0 0
1 39 00000000 00000014 0 0
2 39 dead0000 00000000 0 0
1 38 00000000 20152404 0 0
2 38 00117000 00000000 0 0
1 38 00000000 20150404 0 0
2 10 00000000 00000000 0 0
1 10 00000000 00000000 0 0
1 38 00000000 00000000 0 0
1 39 00000000 00000000 0 0

/* build.f */
+incdir+common
common/dm_reg_pkg.sv
common/dm_bus_pkg.sv
sba/dm_sba.sv
rtl/dm_csrs.sv
rtl/dm_top.sv
tb/tb_dm.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the debug module testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_dm -Mdir obj_dir -o tb_dm

out=$(./obj_dir/tb_dm)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
    exit 0
else
    exit 1
fi

/* tb/tb_dm.sv */
// testbench for dm_top, with pattern player, hart stub, bus memory model and summary
`timescale 1ns/1ps

module tb_dm;

    localparam int TIMEOUT = 200;
    localparam int PAT_MAX = 64;
    localparam int PAT_COLS = 6;
    localparam logic [31:0] PAT_END = 32'hffff_ffff;

    logic                  clk;
    logic                  rst_n;
    dm_reg_pkg::dmi_req_t  dmi_req_i;
    logic                  dmi_valid_i;
    logic                  dmi_ready_o;
    logic                  dmi_resp_valid_o;
    dm_reg_pkg::dmi_resp_t dmi_resp_o;
    logic                  dmi_resp_ready_i;
    logic                  hart_halted_i;
    logic                  hart_resumeack_i;
    logic                  debug_req_o;
    logic                  resumereq_o;
    logic                  ndmreset_o;
    logic                  master_req_o;
    logic                  master_we_o;
    logic [3:0]            master_be_o;
    logic [31:0]           master_addr_o;
    logic [31:0]           master_wdata_o;
    logic                  master_gnt_i;
    logic                  master_rvalid_i;
    logic                  master_err_i;
    logic [31:0]           master_rdata_i;

    logic [31:0] pat_mem [0:PAT_MAX*PAT_COLS-1];
    logic [31:0] mem [0:15];
    int          errors;
    int          timeouts;

    dm_top dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .dmi_req_i        (dmi_req_i),
        .dmi_valid_i      (dmi_valid_i),
        .dmi_ready_o      (dmi_ready_o),
        .dmi_resp_valid_o (dmi_resp_valid_o),
        .dmi_resp_o       (dmi_resp_o),
        .dmi_resp_ready_i (dmi_resp_ready_i),
        .hart_halted_i    (hart_halted_i),
        .hart_resumeack_i (hart_resumeack_i),
        .debug_req_o      (debug_req_o),
        .resumereq_o      (resumereq_o),
        .ndmreset_o       (ndmreset_o),
        .master_req_o     (master_req_o),
        .master_we_o      (master_we_o),
        .master_be_o      (master_be_o),
        .master_addr_o    (master_addr_o),
        .master_wdata_o   (master_wdata_o),
        .master_gnt_i     (master_gnt_i),
        .master_rvalid_i  (master_rvalid_i),
        .master_err_i     (master_err_i),
        .master_rdata_i   (master_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("** Error %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic run_pattern(input int idx);
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expected;
        logic        seen;
        int          cnt;
        int          errors_before;
        string       name;
        op       = pat_mem[idx*PAT_COLS];
        addr     = pat_mem[idx*PAT_COLS+1];
        wdata    = pat_mem[idx*PAT_COLS+2];
        expected = pat_mem[idx*PAT_COLS+3];
        name = $sformatf("pattern %0d op %0d addr %02h", idx, op[1:0], addr[6:0]);
        errors_before = errors;

        // hart stub levels change together with the request
        @(posedge clk);
        hart_halted_i    <= pat_mem[idx*PAT_COLS+4][0];
        hart_resumeack_i <= pat_mem[idx*PAT_COLS+5][0];
        dmi_req_i        <= {addr[6:0], wdata, op[1:0]};
        dmi_valid_i      <= 1'b1;

        seen = 1'b0;
        cnt = 0;
        while (!seen && cnt < TIMEOUT) begin
            @(posedge clk);
            seen = dmi_ready_o;
            cnt = cnt + 1;
        end
        dmi_valid_i <= 1'b0;

        if (!seen) begin
            timeouts = timeouts + 1;
            $display("%s: timed out, the DUT never became ready for the request", name);
        end else begin
            seen = 1'b0;
            cnt = 0;
            while (!seen && cnt < TIMEOUT) begin
                @(posedge clk);
                seen = dmi_resp_valid_o;
                cnt = cnt + 1;
            end
            if (!seen) begin
                timeouts = timeouts + 1;
                $display("%s: timed out, no response came back from the DUT", name);
            end else begin
                check_value(name, expected, dmi_resp_o[33:2]);
                check_value({name, " op"}, 32'd0, {30'd0, dmi_resp_o[1:0]});
                // hart control levels follow a dmcontrol write while dmactive is set
                if (op[1:0] == 2'd2 && addr[6:0] == 7'h10) begin
                    check_value({name, " hart levels"},
                                {29'd0, wdata[31] & wdata[0], wdata[30] & wdata[0],
                                 wdata[1] & wdata[0]},
                                {29'd0, debug_req_o, resumereq_o, ndmreset_o});
                end
                $display("%s: %s", name, (errors == errors_before) ? "pass" : "fail");
            end
        end
    endtask

    // grants after 0 to 2 cycles, rvalid one cycle after the grant
    initial begin : bus_model
        logic [31:0] lfsr;
        logic [1:0]  delay;
        int          i;
        master_gnt_i    = 1'b0;
        master_rvalid_i = 1'b0;
        master_err_i    = 1'b0;
        master_rdata_i  = '0;
        lfsr = 32'hbd95293e;
        for (i = 0; i < 16; i++) begin
            mem[i] = '0;
        end
        forever begin
            @(posedge clk);
            if (rst_n && master_req_o) begin
                check_value("bus byte enables", 32'h0000_000f, {28'd0, master_be_o});
                lfsr = lfsr_step(lfsr);
                delay[0] = lfsr[0];
                lfsr = lfsr_step(lfsr);
                delay[1] = lfsr[0];
                delay = delay % 2'd3;
                repeat (delay) @(posedge clk);
                master_gnt_i <= 1'b1;
                @(posedge clk);
                master_gnt_i    <= 1'b0;
                master_rvalid_i <= 1'b1;
                if (master_addr_o == 32'hdead0000) begin
                    master_err_i   <= 1'b1;
                    master_rdata_i <= '0;
                end else if (master_we_o) begin
                    mem[master_addr_o[5:2]] = master_wdata_o;
                    master_rdata_i <= '0;
                end else begin
                    master_rdata_i <= mem[master_addr_o[5:2]];
                end
                @(posedge clk);
                master_rvalid_i <= 1'b0;
                master_err_i    <= 1'b0;
            end
        end
    end

    initial begin : player
        int idx;
        int i;
        rst_n            = 1'b0;
        dmi_req_i        = '0;
        dmi_valid_i      = 1'b0;
        dmi_resp_ready_i = 1'b1;
        hart_halted_i    = 1'b0;
        hart_resumeack_i = 1'b0;
        errors   = 0;
        timeouts = 0;
        // unused entries read as the end marker
        for (i = 0; i < PAT_MAX*PAT_COLS; i++) begin
            pat_mem[i] = PAT_END;
        end
        $readmemh("tb/dm_patterns.txt", pat_mem);

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        idx = 0;
        while (idx < PAT_MAX && pat_mem[idx*PAT_COLS] != PAT_END && timeouts == 0) begin
            run_pattern(idx);
            idx = idx + 1;
        end

        $display("patterns run: %0d, mismatches: %0d, timeouts: %0d", idx, errors, timeouts);
        if (errors == 0 && timeouts == 0 && idx > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* rtl/dm_top.sv */
// debug module top, register block and system bus engine
`timescale 1ns/1ps

module dm_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  dm_reg_pkg::dmi_req_t  dmi_req_i,
    input  logic                  dmi_valid_i,
    output logic                  dmi_ready_o,
    output logic                  dmi_resp_valid_o,
    output dm_reg_pkg::dmi_resp_t dmi_resp_o,
    input  logic                  dmi_resp_ready_i,
    input  logic                  hart_halted_i,
    input  logic                  hart_resumeack_i,
    output logic                  debug_req_o,
    output logic                  resumereq_o,
    output logic                  ndmreset_o,
    output logic                  master_req_o,
    output logic                  master_we_o,
    output logic [3:0]            master_be_o,
    output dm_bus_pkg::sb_addr_t  master_addr_o,
    output dm_bus_pkg::sb_data_t  master_wdata_o,
    input  logic                  master_gnt_i,
    input  logic                  master_rvalid_i,
    input  logic                  master_err_i,
    input  dm_bus_pkg::sb_data_t  master_rdata_i
);

    logic                 sbbusy;
    logic                 sb_rdata_valid;
    dm_bus_pkg::sb_data_t sb_rdata;
    logic                 sb_err_valid;
    logic                 sb_addr_next_valid;
    dm_bus_pkg::sb_addr_t sb_addr_next;
    logic                 sb_addr_wr;
    logic                 sb_data_wr;
    logic                 sb_data_rd;
    logic                 sb_readonaddr;
    logic                 sb_readondata;
    logic                 sb_autoincr;
    dm_bus_pkg::sb_addr_t sb_addr;
    dm_bus_pkg::sb_data_t sb_wdata;

    dm_csrs u_csrs (
        .clk                  (clk),
        .rst_n                (rst_n),
        .dmi_req_i            (dmi_req_i),
        .dmi_valid_i          (dmi_valid_i),
        .dmi_ready_o          (dmi_ready_o),
        .dmi_resp_valid_o     (dmi_resp_valid_o),
        .dmi_resp_o           (dmi_resp_o),
        .dmi_resp_ready_i     (dmi_resp_ready_i),
        .hart_halted_i        (hart_halted_i),
        .hart_resumeack_i     (hart_resumeack_i),
        .debug_req_o          (debug_req_o),
        .resumereq_o          (resumereq_o),
        .ndmreset_o           (ndmreset_o),
        .sbbusy_i             (sbbusy),
        .sb_rdata_valid_i     (sb_rdata_valid),
        .sb_rdata_i           (sb_rdata),
        .sb_err_valid_i       (sb_err_valid),
        .sb_addr_next_valid_i (sb_addr_next_valid),
        .sb_addr_next_i       (sb_addr_next),
        .sb_addr_wr_o         (sb_addr_wr),
        .sb_data_wr_o         (sb_data_wr),
        .sb_data_rd_o         (sb_data_rd),
        .sb_readonaddr_o      (sb_readonaddr),
        .sb_readondata_o      (sb_readondata),
        .sb_autoincr_o        (sb_autoincr),
        .sb_addr_o            (sb_addr),
        .sb_wdata_o           (sb_wdata)
    );

    dm_sba u_sba (
        .clk                  (clk),
        .rst_n                (rst_n),
        .sb_addr_wr_i         (sb_addr_wr),
        .sb_data_wr_i         (sb_data_wr),
        .sb_data_rd_i         (sb_data_rd),
        .sb_readonaddr_i      (sb_readonaddr),
        .sb_readondata_i      (sb_readondata),
        .sb_autoincr_i        (sb_autoincr),
        .sb_addr_i            (sb_addr),
        .sb_wdata_i           (sb_wdata),
        .sbbusy_o             (sbbusy),
        .sb_rdata_valid_o     (sb_rdata_valid),
        .sb_rdata_o           (sb_rdata),
        .sb_err_valid_o       (sb_err_valid),
        .sb_addr_next_valid_o (sb_addr_next_valid),
        .sb_addr_next_o       (sb_addr_next),
        .master_req_o         (master_req_o),
        .master_we_o          (master_we_o),
        .master_be_o          (master_be_o),
        .master_addr_o        (master_addr_o),
        .master_wdata_o       (master_wdata_o),
        .master_gnt_i         (master_gnt_i),
        .master_rvalid_i      (master_rvalid_i),
        .master_err_i         (master_err_i),
        .master_rdata_i       (master_rdata_i)
    );

endmodule

/* rtl/dm_csrs.sv */
// dmi decode, run control, sba registers and the dmi response sequence
`timescale 1ns/1ps
`include "dm_params.svh"

module dm_csrs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  dm_reg_pkg::dmi_req_t  dmi_req_i,
    input  logic                  dmi_valid_i,
    output logic                  dmi_ready_o,
    output logic                  dmi_resp_valid_o,
    output dm_reg_pkg::dmi_resp_t dmi_resp_o,
    input  logic                  dmi_resp_ready_i,
    input  logic                  hart_halted_i,
    input  logic                  hart_resumeack_i,
    output logic                  debug_req_o,
    output logic                  resumereq_o,
    output logic                  ndmreset_o,
    input  logic                  sbbusy_i,
    input  logic                  sb_rdata_valid_i,
    input  dm_bus_pkg::sb_data_t  sb_rdata_i,
    input  logic                  sb_err_valid_i,
    input  logic                  sb_addr_next_valid_i,
    input  dm_bus_pkg::sb_addr_t  sb_addr_next_i,
    output logic                  sb_addr_wr_o,
    output logic                  sb_data_wr_o,
    output logic                  sb_data_rd_o,
    output logic                  sb_readonaddr_o,
    output logic                  sb_readondata_o,
    output logic                  sb_autoincr_o,
    output dm_bus_pkg::sb_addr_t  sb_addr_o,
    output dm_bus_pkg::sb_data_t  sb_wdata_o
);

    localparam int CTL_HALTREQ      = 31;
    localparam int CTL_RESUMEREQ    = 30;
    localparam int CTL_ACKHAVERESET = 28;
    localparam int CTL_NDMRESET     = 1;
    localparam int CTL_DMACTIVE     = 0;
    // haltreq, resumereq, hartsel, ndmreset and dmactive are kept
    localparam logic [31:0] CTL_WMASK = 32'hc3ff_ffc3;

    localparam int SBCS_BUSYERR  = 22;
    localparam int SBCS_RDONADDR = 20;
    localparam int SBCS_AUTOINCR = 16;
    localparam int SBCS_RDONDATA = 15;

    dm_reg_pkg::dmi_state_e state_q, state_d;
    dm_reg_pkg::dmi_op_e    req_op;
    dm_reg_pkg::dmi_addr_t  req_addr;
    dm_reg_pkg::dmi_data_t  req_data;
    dm_reg_pkg::dmi_data_t  resp_data_q, resp_data_d;
    dm_reg_pkg::dmi_data_t  dmcontrol_q, dmcontrol_d;
    dm_reg_pkg::dmi_data_t  dmstatus;
    dm_reg_pkg::dmi_data_t  sbcs;
    logic [19:0]            hartsel;
    logic                   hart_ok;
    logic                   halted;
    logic                   resumeack;
    logic                   dm_active;
    logic                   accept;
    logic                   sb_ok;
    logic                   havereset_q, havereset_d;
    logic                   sb_busyerr_q, sb_busyerr_d;
    logic                   sb_rdonaddr_q, sb_rdonaddr_d;
    logic                   sb_rdondata_q, sb_rdondata_d;
    logic                   sb_autoincr_q, sb_autoincr_d;
    dm_bus_pkg::sb_error_t  sb_error_q, sb_error_d;
    dm_bus_pkg::sb_addr_t   sbaddress0_q, sbaddress0_d;
    dm_bus_pkg::sb_data_t   sbdata0_q, sbdata0_d;

    assign req_op   = dm_reg_pkg::dmi_op_e'(dmi_req_i[`DM_OP_W-1:0]);
    assign req_data = dmi_req_i[`DM_DATA_W+`DM_OP_W-1:`DM_OP_W];
    assign req_addr = dmi_req_i[`DM_REQ_W-1:`DM_DATA_W+`DM_OP_W];

    // only hart 0 exists
    assign hartsel   = {dmcontrol_q[15:6], dmcontrol_q[25:16]};
    assign hart_ok   = (hartsel == 20'd0);
    assign halted    = hart_ok && hart_halted_i;
    assign resumeack = hart_ok && hart_resumeack_i;
    assign dm_active = dmcontrol_q[CTL_DMACTIVE];
    assign sb_ok     = !sbbusy_i && !sb_busyerr_q;

    assign dmi_ready_o      = (state_q == dm_reg_pkg::DMI_IDLE) && !sbbusy_i;
    assign accept           = dmi_valid_i && dmi_ready_o;
    assign dmi_resp_valid_o = (state_q == dm_reg_pkg::DMI_RESPOND);
    assign dmi_resp_o       = {{`DM_ADDR_W{1'b0}}, resp_data_q, {`DM_OP_W{1'b0}}};

    always_comb begin
        dmstatus        = '0;
        dmstatus[3:0]   = `DM_VERSION;
        // authenticated
        dmstatus[7]     = 1'b1;
        dmstatus[9:8]   = {2{halted}};
        dmstatus[11:10] = {2{hart_ok && !hart_halted_i}};
        dmstatus[15:14] = {2{!hart_ok}};
        dmstatus[17:16] = {2{resumeack}};
        dmstatus[19:18] = {2{havereset_q}};
    end

    always_comb begin
        sbcs = '0;
        if (dm_active) begin
            sbcs[31:29]         = 3'd1;
            sbcs[SBCS_BUSYERR]  = sb_busyerr_q;
            sbcs[21]            = sbbusy_i;
            sbcs[SBCS_RDONADDR] = sb_rdonaddr_q;
            // 32-bit access only
            sbcs[19:17]         = 3'd2;
            sbcs[SBCS_AUTOINCR] = sb_autoincr_q;
            sbcs[SBCS_RDONDATA] = sb_rdondata_q;
            sbcs[14:12]         = sb_error_q;
            sbcs[11:5]          = 7'd32;
            sbcs[2]             = 1'b1;
        end
    end

    always_comb begin
        state_d       = state_q;
        resp_data_d   = resp_data_q;
        dmcontrol_d   = dmcontrol_q;
        havereset_d   = havereset_q;
        sb_busyerr_d  = sb_busyerr_q;
        sb_rdonaddr_d = sb_rdonaddr_q;
        sb_rdondata_d = sb_rdondata_q;
        sb_autoincr_d = sb_autoincr_q;
        sb_error_d    = sb_error_q;
        sbaddress0_d  = sbaddress0_q;
        sbdata0_d     = sbdata0_q;
        sb_addr_wr_o  = 1'b0;
        sb_data_wr_o  = 1'b0;
        sb_data_rd_o  = 1'b0;

        case (state_q)
            dm_reg_pkg::DMI_IDLE: begin
                if (accept) begin
                    state_d = dm_reg_pkg::DMI_RESPOND;
                end
            end
            dm_reg_pkg::DMI_RESPOND: begin
                if (dmi_resp_ready_i) begin
                    state_d = dm_reg_pkg::DMI_IDLE;
                end
            end
            default: state_d = dm_reg_pkg::DMI_IDLE;
        endcase

        if (accept) begin
            resp_data_d = '0;
            if (req_op == dm_reg_pkg::DMI_OP_READ) begin
                case (req_addr)
                    `DM_A_DMSTATUS:   resp_data_d = dmstatus;
                    `DM_A_DMCONTROL:  resp_data_d = dmcontrol_q;
                    `DM_A_HARTINFO:   resp_data_d = `DM_HARTINFO;
                    `DM_A_HALTSUM0,
                    `DM_A_HALTSUM1:   resp_data_d = {31'd0, halted};
                    `DM_A_SBCS:       resp_data_d = sbcs;
                    `DM_A_SBADDRESS0: resp_data_d = sbaddress0_q;
                    `DM_A_SBDATA0: begin
                        resp_data_d = sbdata0_q;
                        if (!sb_ok) begin
                            sb_busyerr_d = 1'b1;
                        end else begin
                            sb_data_rd_o = dm_active && (sb_error_q == '0);
                        end
                    end
                    default: ;
                endcase
            end else if (req_op == dm_reg_pkg::DMI_OP_WRITE) begin
                case (req_addr)
                    `DM_A_DMCONTROL: begin
                        dmcontrol_d = req_data & CTL_WMASK;
                        if (req_data[CTL_ACKHAVERESET]) begin
                            havereset_d = 1'b0;
                        end
                    end
                    `DM_A_SBCS: begin
                        if (sbbusy_i) begin
                            sb_busyerr_d = 1'b1;
                        end else begin
                            sb_rdonaddr_d = req_data[SBCS_RDONADDR];
                            sb_rdondata_d = req_data[SBCS_RDONDATA];
                            sb_autoincr_d = req_data[SBCS_AUTOINCR];
                            // error bits are write 1 to clear
                            sb_busyerr_d  = sb_busyerr_q & ~req_data[SBCS_BUSYERR];
                            sb_error_d    = sb_error_q & ~req_data[14:12];
                        end
                    end
                    `DM_A_SBADDRESS0: begin
                        if (!sb_ok) begin
                            sb_busyerr_d = 1'b1;
                        end else begin
                            sbaddress0_d = req_data;
                            sb_addr_wr_o = dm_active && (sb_error_q == '0);
                        end
                    end
                    `DM_A_SBDATA0: begin
                        if (!sb_ok) begin
                            sb_busyerr_d = 1'b1;
                        end else begin
                            sbdata0_d    = req_data;
                            sb_data_wr_o = dm_active && (sb_error_q == '0);
                        end
                    end
                    default: ;
                endcase
            end
        end

        // resume request drops once the hart acknowledges
        if (dmcontrol_q[CTL_RESUMEREQ] && resumeack) begin
            dmcontrol_d[CTL_RESUMEREQ] = 1'b0;
        end
        if (ndmreset_o) begin
            havereset_d = 1'b1;
        end

        // completion of a bus access
        if (sb_rdata_valid_i) begin
            sbdata0_d = sb_rdata_i;
        end
        if (sb_err_valid_i) begin
            sb_error_d = `DM_SB_ERR_BADADDR;
        end
        if (sb_addr_next_valid_i) begin
            sbaddress0_d = sb_addr_next_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q       <= dm_reg_pkg::DMI_IDLE;
            dmcontrol_q   <= '0;
            havereset_q   <= 1'b1;
            sb_busyerr_q  <= 1'b0;
            sb_rdonaddr_q <= 1'b0;
            sb_rdondata_q <= 1'b0;
            sb_autoincr_q <= 1'b0;
            sb_error_q    <= '0;
            sbaddress0_q  <= '0;
            sbdata0_q     <= '0;
        end else begin
            state_q     <= state_d;
            havereset_q <= havereset_d;
            // inactive module holds everything but dmactive at zero
            if (dmcontrol_d[CTL_DMACTIVE]) begin
                dmcontrol_q   <= dmcontrol_d;
                sb_busyerr_q  <= sb_busyerr_d;
                sb_rdonaddr_q <= sb_rdonaddr_d;
                sb_rdondata_q <= sb_rdondata_d;
                sb_autoincr_q <= sb_autoincr_d;
                sb_error_q    <= sb_error_d;
                sbaddress0_q  <= sbaddress0_d;
                sbdata0_q     <= sbdata0_d;
            end else begin
                dmcontrol_q   <= '0;
                sb_busyerr_q  <= 1'b0;
                sb_rdonaddr_q <= 1'b0;
                sb_rdondata_q <= 1'b0;
                sb_autoincr_q <= 1'b0;
                sb_error_q    <= '0;
                sbaddress0_q  <= '0;
                sbdata0_q     <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        resp_data_q <= resp_data_d;
    end

    assign debug_req_o     = dmcontrol_q[CTL_HALTREQ];
    assign resumereq_o     = dmcontrol_q[CTL_RESUMEREQ];
    assign ndmreset_o      = dmcontrol_q[CTL_NDMRESET];
    assign sb_readonaddr_o = sb_rdonaddr_q;
    assign sb_readondata_o = sb_rdondata_q;
    assign sb_autoincr_o   = sb_autoincr_q;
    assign sb_addr_o       = sbaddress0_q;
    assign sb_wdata_o      = sbdata0_q;

endmodule

/* sba/dm_sba.sv */
// system bus master engine, 32-bit reads and writes with busy and error report
`timescale 1ns/1ps

module dm_sba (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sb_addr_wr_i,
    input  logic                 sb_data_wr_i,
    input  logic                 sb_data_rd_i,
    input  logic                 sb_readonaddr_i,
    input  logic                 sb_readondata_i,
    input  logic                 sb_autoincr_i,
    input  dm_bus_pkg::sb_addr_t sb_addr_i,
    input  dm_bus_pkg::sb_data_t sb_wdata_i,
    output logic                 sbbusy_o,
    output logic                 sb_rdata_valid_o,
    output dm_bus_pkg::sb_data_t sb_rdata_o,
    output logic                 sb_err_valid_o,
    output logic                 sb_addr_next_valid_o,
    output dm_bus_pkg::sb_addr_t sb_addr_next_o,
    output logic                 master_req_o,
    output logic                 master_we_o,
    output logic [3:0]           master_be_o,
    output dm_bus_pkg::sb_addr_t master_addr_o,
    output dm_bus_pkg::sb_data_t master_wdata_o,
    input  logic                 master_gnt_i,
    input  logic                 master_rvalid_i,
    input  logic                 master_err_i,
    input  dm_bus_pkg::sb_data_t master_rdata_i
);

    dm_bus_pkg::sba_state_e state_q, state_d;
    logic                   write_q;
    logic                   start_rd;
    logic                   start_wr;
    logic                   done;

    assign start_rd = (sb_addr_wr_i && sb_readonaddr_i) || (sb_data_rd_i && sb_readondata_i);
    assign start_wr = sb_data_wr_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dm_bus_pkg::SBA_IDLE: begin
                if (start_wr) begin
                    state_d = dm_bus_pkg::SBA_WRITE;
                end else if (start_rd) begin
                    state_d = dm_bus_pkg::SBA_READ;
                end
            end
            // hold the request until granted
            dm_bus_pkg::SBA_READ,
            dm_bus_pkg::SBA_WRITE: begin
                if (master_gnt_i) begin
                    state_d = dm_bus_pkg::SBA_WAIT_RVALID;
                end
            end
            dm_bus_pkg::SBA_WAIT_RVALID: begin
                if (master_rvalid_i) begin
                    state_d = dm_bus_pkg::SBA_IDLE;
                end
            end
            default: state_d = dm_bus_pkg::SBA_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= dm_bus_pkg::SBA_IDLE;
            write_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // direction is needed again when rvalid comes back
            if (state_q == dm_bus_pkg::SBA_IDLE && state_d != dm_bus_pkg::SBA_IDLE) begin
                write_q <= start_wr;
            end
        end
    end

    assign done = (state_q == dm_bus_pkg::SBA_WAIT_RVALID) && master_rvalid_i;

    assign sbbusy_o     = (state_q != dm_bus_pkg::SBA_IDLE);
    assign master_req_o = (state_q == dm_bus_pkg::SBA_READ) ||
                          (state_q == dm_bus_pkg::SBA_WRITE);
    assign master_we_o  = (state_q == dm_bus_pkg::SBA_WRITE);
    assign master_be_o  = 4'hf;

    // address and data registers stay stable while busy
    assign master_addr_o  = sb_addr_i;
    assign master_wdata_o = sb_wdata_i;

    assign sb_rdata_valid_o     = done && !write_q && !master_err_i;
    assign sb_rdata_o           = master_rdata_i;
    assign sb_err_valid_o       = done && master_err_i;
    assign sb_addr_next_valid_o = done && !master_err_i && sb_autoincr_i;
    assign sb_addr_next_o       = sb_addr_i + 32'd4;

endmodule

/* common/dm_bus_pkg.sv */
// system bus address, data and error types, and the sba engine states
`include "dm_params.svh"

package dm_bus_pkg;

    typedef logic [31:0] sb_addr_t;
    typedef logic [`DM_DATA_W-1:0] sb_data_t;
    typedef logic [2:0] sb_error_t;

    typedef enum logic [1:0] {
        SBA_IDLE,
        SBA_READ,
        SBA_WRITE,
        SBA_WAIT_RVALID
    } sba_state_e;

endpackage

/* common/dm_reg_pkg.sv */
// dmi field types, operation encoding and response sequence states
`include "dm_params.svh"

package dm_reg_pkg;

    typedef logic [`DM_ADDR_W-1:0] dmi_addr_t;
    typedef logic [`DM_DATA_W-1:0] dmi_data_t;

    // address on top, data in the middle, op in the low bits
    typedef logic [`DM_REQ_W-1:0] dmi_req_t;

    // same layout, op field of zero means success
    typedef logic [`DM_REQ_W-1:0] dmi_resp_t;

    typedef enum logic [`DM_OP_W-1:0] {
        DMI_OP_NOP   = 2'd0,
        DMI_OP_READ  = 2'd1,
        DMI_OP_WRITE = 2'd2
    } dmi_op_e;

    typedef enum logic {
        DMI_IDLE,
        DMI_RESPOND
    } dmi_state_e;

endpackage

/* common/dm_params.svh */
// widths, dmi register addresses and fixed values of the debug module
`ifndef DM_PARAMS_SVH
`define DM_PARAMS_SVH

// dmi request fields
`define DM_ADDR_W 7
`define DM_DATA_W 32
`define DM_OP_W 2
`define DM_REQ_W (`DM_ADDR_W + `DM_DATA_W + `DM_OP_W)

// debug register map
`define DM_A_DMCONTROL 7'h10
`define DM_A_DMSTATUS 7'h11
`define DM_A_HARTINFO 7'h12
`define DM_A_HALTSUM1 7'h13
`define DM_A_SBCS 7'h38
`define DM_A_SBADDRESS0 7'h39
`define DM_A_SBDATA0 7'h3c
`define DM_A_HALTSUM0 7'h40

// spec 0.13
`define DM_VERSION 4'd2

// nscratch 2, dataaccess 1, datasize 1, dataaddr 0x380
`define DM_HARTINFO 32'h0021_1380

// sberror code for a bus error response
`define DM_SB_ERR_BADADDR 3'd2

`endif
